/* graph_macros.svh */
`ifndef GRAPH_MACROS_SVH
`define GRAPH_MACROS_SVH

// number of addressable nodes
// node_t width follows as clog2 of this value
`define MAX_NODES 64

// capacity of the destination list
// edge_ptr_t width follows as clog2 of this value
`define MAX_EDGES 256

// reply FIFO entries
// the control allows up to two reads in flight against this depth,
// so the free count stays two bits wide
`define REPLY_DEPTH 2

`endif

/* graph_types_pkg.sv */
`include "graph_macros.svh"

package graph_types_pkg;

    // node number
    typedef logic [$clog2(`MAX_NODES)-1:0] node_t;

    // position in the destination list
    typedef logic [$clog2(`MAX_EDGES)-1:0] edge_ptr_t;

    // stored edge count, one bit wider so a full store is visible
    typedef logic [$clog2(`MAX_EDGES):0] edge_cnt_t;

    // per-source record
    typedef struct packed {
        logic      has_edges;
        edge_ptr_t first;
        edge_ptr_t last;
    } index_entry_t;

    typedef enum logic [1:0] {
        LOAD,
        IDLE,
        LOOKUP,
        STREAM
    } ctrl_state_t;

endpackage

/* graph_stream_pkg.sv */
package graph_stream_pkg;

    import graph_types_pkg::*;

    // one edge on the load stream
    // first_of_src opens a new source group and restarts its list
    typedef struct packed {
        node_t src;
        node_t dst;
        logic  first_of_src;
    } load_entry_t;

    // one beat on the reply stream
    // a node without edges sends a single beat with no_edges and last set
    typedef struct packed {
        node_t node;
        logic  last;
        logic  no_edges;
    } reply_beat_t;

endpackage

/* adjacency_ctrl.sv */
`timescale 1ns/100ps

`include "graph_macros.svh"

module adjacency_ctrl (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          load_valid,
    input  logic                          load_done,
    input  logic                          query_valid,
    input  graph_types_pkg::node_t        query_node,
    input  graph_types_pkg::index_entry_t entry,
    input  graph_types_pkg::edge_cnt_t    store_count,
    input  logic [1:0]                    buf_free,
    output logic                          load_ready,
    output logic                          query_ready,
    output logic                          idx_wr_en,
    output logic                          store_wr_en,
    output logic                          lookup_en,
    output graph_types_pkg::node_t        lookup_node,
    output logic                          rd_en,
    output graph_types_pkg::edge_ptr_t    rd_ptr,
    output logic                          beat_push,
    output logic                          beat_last,
    output logic                          beat_no_edges
);

    import graph_types_pkg::*;

    typedef struct packed {
        logic valid;
        logic last;
        logic no_edges;
    } flight_t;

    ctrl_state_t state;
    ctrl_state_t state_nxt;

    // latched lookup result
    edge_ptr_t cur_ptr;
    edge_ptr_t last_ptr;
    logic      has_edges;

    logic      issue_done;
    logic      issue;
    flight_t   issue_f;
    flight_t   pend_q;

    // load phase
    assign load_ready  = (state == LOAD) && (store_count != edge_cnt_t'(`MAX_EDGES));
    assign idx_wr_en   = load_valid && load_ready;
    assign store_wr_en = idx_wr_en;

    // query accept, index read happens on the accepting edge
    assign query_ready = (state == IDLE);
    assign lookup_en   = query_valid && query_ready;
    assign lookup_node = query_node;

    // a read only goes out if its beat is sure to find a slot
    assign issue = (state == STREAM) && !issue_done && (buf_free > {1'b0, pend_q.valid});

    assign issue_f.valid    = issue;
    assign issue_f.last     = !has_edges || (cur_ptr == last_ptr);
    assign issue_f.no_edges = !has_edges;

    // empty node needs no memory read, only the flagged beat
    assign rd_en  = issue && has_edges;
    assign rd_ptr = cur_ptr;

    // store data arrives one cycle after the read
    assign beat_push     = pend_q.valid;
    assign beat_last     = pend_q.last;
    assign beat_no_edges = pend_q.no_edges;

    always_comb begin
        state_nxt = state;
        case (state)
            LOAD: begin
                if (load_done) begin
                    state_nxt = IDLE;
                end
            end
            IDLE: begin
                if (lookup_en) begin
                    state_nxt = LOOKUP;
                end
            end
            LOOKUP: begin
                state_nxt = STREAM;
            end
            STREAM: begin
                if (pend_q.valid && pend_q.last) begin
                    state_nxt = IDLE;
                end
            end
            default: begin
                state_nxt = LOAD;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= LOAD;
            pend_q     <= '0;
            issue_done <= 1'b0;
        end else begin
            state  <= state_nxt;
            pend_q <= issue_f;
            if (state == LOOKUP) begin
                issue_done <= 1'b0;
            end else if (issue && issue_f.last) begin
                issue_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == LOOKUP) begin
            cur_ptr   <= entry.first;
            last_ptr  <= entry.last;
            has_edges <= entry.has_edges;
        end else if (issue) begin
            cur_ptr <= cur_ptr + 1'b1;
        end
    end

    // reads stay inside the group recorded by the index table
    a_rd_within_group: assert property (@(posedge clk) disable iff (!arst_n)
        rd_en |-> rd_ptr <= last_ptr);

    // once loading is over the store stops growing
    a_no_load_after_done: assert property (@(posedge clk) disable iff (!arst_n)
        (state != LOAD) |=> $stable(store_count));

endmodule

/* node_index_table.sv */
`timescale 1ns/100ps

`include "graph_macros.svh"

module node_index_table (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          wr_en,
    input  graph_stream_pkg::load_entry_t load_entry,
    input  graph_types_pkg::edge_ptr_t    append_ptr,
    input  logic                          lookup_en,
    input  graph_types_pkg::node_t        lookup_node,
    output graph_types_pkg::index_entry_t entry
);

    import graph_types_pkg::*;

    // flags must start clear, pointers only matter once a flag is set
    logic [`MAX_NODES-1:0] has_edges;
    edge_ptr_t             first_mem [`MAX_NODES];
    edge_ptr_t             last_mem  [`MAX_NODES];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            has_edges <= '0;
        end else if (wr_en && load_entry.first_of_src) begin
            has_edges[load_entry.src] <= 1'b1;
        end
    end

    // a new group restarts both pointers, later edges extend it
    always_ff @(posedge clk) begin
        if (wr_en) begin
            if (load_entry.first_of_src) begin
                first_mem[load_entry.src] <= append_ptr;
            end
            last_mem[load_entry.src] <= append_ptr;
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_en) begin
            entry.has_edges <= has_edges[lookup_node];
            entry.first     <= first_mem[lookup_node];
            entry.last      <= last_mem[lookup_node];
        end
    end

    // group pointers grow with the append pointer
    a_last_not_before_first: assert property (@(posedge clk) disable iff (!arst_n)
        (wr_en && !load_entry.first_of_src && has_edges[load_entry.src])
            |-> append_ptr >= first_mem[load_entry.src]);

endmodule

/* edge_list_store.sv */
`timescale 1ns/100ps

`include "graph_macros.svh"

module edge_list_store (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       wr_en,
    input  graph_types_pkg::node_t     dst,
    input  logic                       rd_en,
    input  graph_types_pkg::edge_ptr_t rd_ptr,
    output graph_types_pkg::edge_ptr_t append_ptr,
    output graph_types_pkg::edge_cnt_t count,
    output graph_types_pkg::node_t     rd_data
);

    import graph_types_pkg::*;

    node_t mem [`MAX_EDGES];

    // entries are appended in order, so the count doubles as the write position
    assign append_ptr = edge_ptr_t'(count);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else if (wr_en) begin
            count <= count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[append_ptr] <= dst;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_ptr];
        end
    end

    // loader must be held off once every slot is taken
    a_no_write_when_full: assert property (@(posedge clk) disable iff (!arst_n)
        wr_en |-> count != edge_cnt_t'(`MAX_EDGES));

endmodule

/* reply_buffer.sv */
`timescale 1ns/100ps

`include "graph_macros.svh"

module reply_buffer (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          push,
    input  graph_types_pkg::node_t        push_node,
    input  logic                          push_last,
    input  logic                          push_no_edges,
    input  logic                          reply_ready,
    output logic                          reply_valid,
    output graph_stream_pkg::reply_beat_t reply,
    output logic [1:0]                    free
);

    import graph_stream_pkg::*;

    reply_beat_t                      mem [`REPLY_DEPTH];
    logic [$clog2(`REPLY_DEPTH)-1:0]  wr_idx;
    logic [$clog2(`REPLY_DEPTH)-1:0]  rd_idx;
    logic [1:0]                       count;
    logic                             pop;

    assign reply_valid = (count != 2'd0);
    assign reply       = mem[rd_idx];
    assign pop         = reply_valid && reply_ready;

    // a slot leaving this cycle already counts as free
    assign free = 2'(`REPLY_DEPTH) - count + {1'b0, pop};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_idx <= '0;
            rd_idx <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_idx <= wr_idx + 1'b1;
            end
            if (pop) begin
                rd_idx <= rd_idx + 1'b1;
            end
            count <= count + {1'b0, push} - {1'b0, pop};
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_idx] <= '{node: push_node, last: push_last, no_edges: push_no_edges};
        end
    end

    // control only pushes when it has reserved a slot
    a_no_push_when_full: assert property (@(posedge clk) disable iff (!arst_n)
        push |-> count != 2'(`REPLY_DEPTH));

    // a stalled beat holds until the consumer takes it
    a_reply_stable: assert property (@(posedge clk) disable iff (!arst_n)
        (reply_valid && !reply_ready) |=> reply_valid && $stable(reply));

endmodule

/* adjacency_map.sv */
`timescale 1ns/100ps

module adjacency_map (
    input  logic                          clk,
    input  logic                          arst_n,
    // load stream
    input  logic                          load_valid,
    output logic                          load_ready,
    input  graph_stream_pkg::load_entry_t load_entry,
    input  logic                          load_done,
    // query stream
    input  logic                          query_valid,
    output logic                          query_ready,
    input  graph_types_pkg::node_t        query_node,
    // reply stream
    output logic                          reply_valid,
    input  logic                          reply_ready,
    output graph_stream_pkg::reply_beat_t reply
);

    import graph_types_pkg::*;

    logic         idx_wr_en;
    logic         store_wr_en;
    logic         lookup_en;
    logic         rd_en;
    logic         beat_push;
    logic         beat_last;
    logic         beat_no_edges;
    logic [1:0]   buf_free;
    node_t        lookup_node;
    node_t        rd_data;
    edge_ptr_t    rd_ptr;
    edge_ptr_t    append_ptr;
    edge_cnt_t    store_count;
    index_entry_t entry;

    adjacency_ctrl adjacency_ctrl_inst (
        .clk           (clk),
        .arst_n        (arst_n),
        .load_valid    (load_valid),
        .load_done     (load_done),
        .query_valid   (query_valid),
        .query_node    (query_node),
        .entry         (entry),
        .store_count   (store_count),
        .buf_free      (buf_free),
        .load_ready    (load_ready),
        .query_ready   (query_ready),
        .idx_wr_en     (idx_wr_en),
        .store_wr_en   (store_wr_en),
        .lookup_en     (lookup_en),
        .lookup_node   (lookup_node),
        .rd_en         (rd_en),
        .rd_ptr        (rd_ptr),
        .beat_push     (beat_push),
        .beat_last     (beat_last),
        .beat_no_edges (beat_no_edges)
    );

    node_index_table node_index_table_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .wr_en       (idx_wr_en),
        .load_entry  (load_entry),
        .append_ptr  (append_ptr),
        .lookup_en   (lookup_en),
        .lookup_node (lookup_node),
        .entry       (entry)
    );

    edge_list_store edge_list_store_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .wr_en      (store_wr_en),
        .dst        (load_entry.dst),
        .rd_en      (rd_en),
        .rd_ptr     (rd_ptr),
        .append_ptr (append_ptr),
        .count      (store_count),
        .rd_data    (rd_data)
    );

    reply_buffer reply_buffer_inst (
        .clk           (clk),
        .arst_n        (arst_n),
        .push          (beat_push),
        .push_node     (rd_data),
        .push_last     (beat_last),
        .push_no_edges (beat_no_edges),
        .reply_ready   (reply_ready),
        .reply_valid   (reply_valid),
        .reply         (reply),
        .free          (buf_free)
    );

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // release lines up with a rising edge
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule

/* adjacency_checker.sv */
`timescale 1ns/100ps

`include "graph_macros.svh"

module adjacency_checker (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          load_valid,
    input  logic                          load_ready,
    input  graph_stream_pkg::load_entry_t load_entry,
    input  logic                          load_done,
    input  logic                          query_valid,
    input  logic                          query_ready,
    input  graph_types_pkg::node_t        query_node,
    input  logic                          reply_valid,
    input  logic                          reply_ready,
    input  graph_stream_pkg::reply_beat_t reply,
    input  logic                          latency_chk,
    output int                            mismatch_cnt,
    output int                            other_cnt,
    output int                            pending_beats
);

    import graph_types_pkg::*;
    import graph_stream_pkg::*;

    localparam int FIRST_BEAT_LATENCY = 3;

    // reference graph, one destination queue per source
    node_t       adj [`MAX_NODES][$];
    reply_beat_t exp_q [$];
    int          exp_len_q [$];
    reply_beat_t exp_b;
    int          exp_len;

    int          mism = 0;
    int          fails = 0;
    int          pend = 0;
    int          cyc = 0;
    int          stored = 0;
    int          beat_cnt = 0;
    int          accept_cyc = 0;
    logic        done_seen = 1'b0;
    logic        await_first = 1'b0;
    logic        latency_armed = 1'b0;
    logic        stall_prev = 1'b0;
    reply_beat_t reply_prev = '0;

    assign mismatch_cnt  = mism;
    assign other_cnt     = fails;
    assign pending_beats = pend;

    task automatic flag_mismatch(input string sig, input logic [31:0] expected,
                                 input logic [31:0] actual);
        $display("MISMATCH %s expected 0x%0h actual 0x%0h at %0t", sig, expected, actual, $time);
        mism = mism + 1;
    endtask

    task automatic raise_failure(input string what);
        $display("ERROR %s at %0t", what, $time);
        fails = fails + 1;
    endtask

    task automatic expect_bit(input string sig, input logic expected, input logic actual);
        if (actual !== expected) begin
            flag_mismatch(sig, 32'(expected), 32'(actual));
        end
    endtask

    // inputs change on the rising edge, so the falling edge sees settled values
    always @(negedge clk) begin
        cyc = cyc + 1;
        if (!arst_n) begin
            expect_bit("load_ready", 1'b1, load_ready);
            expect_bit("query_ready", 1'b0, query_ready);
            expect_bit("reply_valid", 1'b0, reply_valid);
        end else begin
            if (!done_seen) begin
                expect_bit("load_ready", stored < `MAX_EDGES, load_ready);
                expect_bit("query_ready", 1'b0, query_ready);
                expect_bit("reply_valid", 1'b0, reply_valid);
            end else begin
                expect_bit("load_ready", 1'b0, load_ready);
            end

            // a stalled beat must not move
            if (stall_prev) begin
                if (reply_valid !== 1'b1) begin
                    flag_mismatch("reply_valid", 32'h1, 32'(reply_valid));
                end else if (reply !== reply_prev) begin
                    flag_mismatch("reply", 32'(reply_prev), 32'(reply));
                end
            end
            stall_prev = reply_valid && !reply_ready;
            reply_prev = reply;

            // accept is seen half a cycle before its edge
            if (reply_valid && await_first) begin
                await_first = 1'b0;
                if (latency_armed && (cyc - accept_cyc - 1 != FIRST_BEAT_LATENCY)) begin
                    flag_mismatch("first beat latency", 32'(FIRST_BEAT_LATENCY),
                                  32'(cyc - accept_cyc - 1));
                end
            end

            if (reply_valid && reply_ready) begin
                if (exp_q.size() == 0) begin
                    raise_failure("reply beat arrived with no query outstanding");
                end else begin
                    exp_b = exp_q.pop_front();
                    expect_bit("reply.no_edges", exp_b.no_edges, reply.no_edges);
                    expect_bit("reply.last", exp_b.last, reply.last);
                    // node field carries no meaning on an empty reply
                    if (!exp_b.no_edges && reply.node !== exp_b.node) begin
                        flag_mismatch("reply.node", 32'(exp_b.node), 32'(reply.node));
                    end
                end
                beat_cnt = beat_cnt + 1;
                if (reply.last) begin
                    if (exp_len_q.size() != 0) begin
                        exp_len = exp_len_q.pop_front();
                        if (beat_cnt != exp_len) begin
                            flag_mismatch("beats per query", 32'(exp_len), 32'(beat_cnt));
                        end
                    end
                    beat_cnt = 0;
                end
            end

            if (load_valid && load_ready) begin
                if (done_seen) begin
                    raise_failure("load entry accepted after load_done");
                end
                // a repeated group replaces the earlier one
                if (load_entry.first_of_src) begin
                    adj[load_entry.src].delete();
                end
                adj[load_entry.src].push_back(load_entry.dst);
                stored = stored + 1;
            end

            if (query_valid && query_ready) begin
                if (!done_seen) begin
                    raise_failure("query accepted during the load phase");
                end
                if (adj[query_node].size() == 0) begin
                    exp_b = '{node: '0, last: 1'b1, no_edges: 1'b1};
                    exp_q.push_back(exp_b);
                    exp_len_q.push_back(1);
                end else begin
                    for (int i = 0; i < adj[query_node].size(); i++) begin
                        exp_b = '{node: adj[query_node][i],
                                  last: (i == adj[query_node].size() - 1),
                                  no_edges: 1'b0};
                        exp_q.push_back(exp_b);
                    end
                    exp_len_q.push_back(adj[query_node].size());
                end
                accept_cyc    = cyc;
                await_first   = 1'b1;
                latency_armed = latency_chk && reply_ready;
            end

            if (load_done) begin
                done_seen = 1'b1;
            end
            pend = exp_q.size();
        end
    end

endmodule

/* tb_adjacency_map.sv */
`timescale 1ns/100ps

`include "graph_macros.svh"

module tb_adjacency_map;

    import graph_types_pkg::*;
    import graph_stream_pkg::*;

    localparam int NUM_SOURCES  = 40;
    localparam int MAX_FANOUT   = 6;
    localparam int NUM_QUERIES  = 120;
    localparam int HELD_QUERIES = 10;
    localparam int RESET_CYCLES = 16;
    localparam int READY_PCT    = 70;

    logic        clk;
    logic        arst_n;
    logic        load_valid;
    logic        load_ready;
    load_entry_t load_entry;
    logic        load_done;
    logic        query_valid;
    logic        query_ready;
    node_t       query_node;
    logic        reply_valid;
    logic        reply_ready = 1'b0;
    reply_beat_t reply;

    logic        hold_ready = 1'b0;
    logic        ready_pat [256];
    load_entry_t load_q [$];
    int          seed;
    int          cycle_cnt = 0;
    int          cycle_limit = 1000000;
    int          mismatch_cnt;
    int          other_cnt;
    int          pending_beats;

    tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(RESET_CYCLES)) tb_clock_gen_inst (
        .clk    (clk),
        .arst_n (arst_n)
    );

    adjacency_map adjacency_map_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .load_valid  (load_valid),
        .load_ready  (load_ready),
        .load_entry  (load_entry),
        .load_done   (load_done),
        .query_valid (query_valid),
        .query_ready (query_ready),
        .query_node  (query_node),
        .reply_valid (reply_valid),
        .reply_ready (reply_ready),
        .reply       (reply)
    );

    adjacency_checker adjacency_checker_inst (
        .clk           (clk),
        .arst_n        (arst_n),
        .load_valid    (load_valid),
        .load_ready    (load_ready),
        .load_entry    (load_entry),
        .load_done     (load_done),
        .query_valid   (query_valid),
        .query_ready   (query_ready),
        .query_node    (query_node),
        .reply_valid   (reply_valid),
        .reply_ready   (reply_ready),
        .reply         (reply),
        .latency_chk   (hold_ready),
        .mismatch_cnt  (mismatch_cnt),
        .other_cnt     (other_cnt),
        .pending_beats (pending_beats)
    );

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % n;
    endfunction

    // entered right after a rising edge, returns right after the transfer edge
    task automatic send_load(input load_entry_t e);
        load_valid <= 1'b1;
        load_entry <= e;
        @(negedge clk);
        while (load_ready !== 1'b1) @(negedge clk);
        @(posedge clk);
    endtask

    task automatic send_query(input node_t n);
        query_valid <= 1'b1;
        query_node  <= n;
        @(negedge clk);
        while (query_ready !== 1'b1) @(negedge clk);
        @(posedge clk);
        query_valid <= 1'b0;
    endtask

    task automatic wait_reply_end();
        @(negedge clk);
        while (!(reply_valid === 1'b1 && reply_ready === 1'b1 && reply.last === 1'b1)) begin
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    always @(posedge clk) begin
        reply_ready <= hold_ready ? 1'b1 : ready_pat[cycle_cnt[7:0]];
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout: run passed its limit of %0d cycles", cycle_limit);
            $display("error counts: %0d mismatches, %0d other failures",
                     mismatch_cnt, other_cnt + 1);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        int          order [`MAX_NODES];
        int          pick;
        int          tmp;
        int          fanout;
        int          extra_errors;
        load_entry_t e;
        node_t       first_node;
        node_t       qn;

        seed         = 32'h7d5b_025d;
        load_valid   = 1'b0;
        load_entry   = '0;
        load_done    = 1'b0;
        query_valid  = 1'b0;
        query_node   = '0;
        extra_errors = 0;

        for (int i = 0; i < 256; i++) begin
            ready_pat[i] = (rand_below(100) < READY_PCT);
        end

        // sources in shuffled order, no repeats
        for (int i = 0; i < `MAX_NODES; i++) begin
            order[i] = i;
        end
        for (int i = `MAX_NODES - 1; i > 0; i--) begin
            pick        = rand_below(i + 1);
            tmp         = order[i];
            order[i]    = order[pick];
            order[pick] = tmp;
        end
        for (int s = 0; s < NUM_SOURCES; s++) begin
            fanout = rand_below(MAX_FANOUT + 1);
            for (int j = 0; j < fanout; j++) begin
                e.src          = node_t'(order[s]);
                e.dst          = node_t'(rand_below(`MAX_NODES));
                e.first_of_src = (j == 0);
                load_q.push_back(e);
            end
        end
        first_node = node_t'(rand_below(`MAX_NODES));

        // latency plus up to seven beats at four cycles each, per query
        cycle_limit = RESET_CYCLES + load_q.size() + NUM_QUERIES * (3 + 7 * 4) + 100;

        wait (arst_n === 1'b1);
        @(posedge clk);

        // first query waits through the whole load phase
        query_valid <= 1'b1;
        query_node  <= first_node;

        foreach (load_q[k]) begin
            send_load(load_q[k]);
        end
        load_valid <= 1'b0;
        load_done  <= 1'b1;

        for (int q = 0; q < NUM_QUERIES; q++) begin
            if (q == NUM_QUERIES - HELD_QUERIES) begin
                hold_ready <= 1'b1;
                @(posedge clk);
            end
            if (q == 0) begin
                qn = first_node;
            end else begin
                qn = node_t'(rand_below(`MAX_NODES));
            end
            send_query(qn);
            if (q == 0) begin
                // late edge offer that the store must refuse
                load_valid <= 1'b1;
            end
            wait_reply_end();
        end

        repeat (4) @(posedge clk);

        if (pending_beats != 0) begin
            $display("replies incomplete at end of run: %0d expected beats never arrived",
                     pending_beats);
            extra_errors = extra_errors + 1;
        end
        $display("error counts: %0d mismatches, %0d other failures",
                 mismatch_cnt, other_cnt + extra_errors);
        if (mismatch_cnt == 0 && other_cnt + extra_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+.
graph_types_pkg.sv
graph_stream_pkg.sv
adjacency_ctrl.sv
node_index_table.sv
edge_list_store.sv
reply_buffer.sv
adjacency_map.sv
tb_clock_gen.sv
adjacency_checker.sv
tb_adjacency_map.sv

/* Makefile */
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing
TOP        ?= tb_adjacency_map
FILELIST   ?= files.f
OBJ_DIR    ?= obj_dir
PASS_MSG   := Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
